// ==== axi_pkg.sv ====
package axi_pkg;

    // SRAM geometry
    localparam int sram_words = 512;
    localparam int sram_idx_w = $clog2(sram_words);
    localparam int sram_bytes = sram_words * (rw_pkg::data_w / 8);
    localparam logic [rw_pkg::addr_w-1:0] sram_base = '0;

    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01
    } axi_burst_e;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_e;

    // Read address channel
    typedef struct packed {
        logic                      arvalid;
        logic [rw_pkg::addr_w-1:0] araddr;
        logic [7:0]                arlen;   // Beats minus one
        logic [2:0]                arsize;  // log2 of bytes per beat
        axi_burst_e                arburst;
    } axi_ar_t;

    // Read data channel
    typedef struct packed {
        logic                      rvalid;
        logic [rw_pkg::data_w-1:0] rdata;
        axi_resp_e                 rresp;
        logic                      rlast;
    } axi_r_t;

    // Read master states
    typedef enum logic [1:0] {
        M_IDLE,
        M_AR,
        M_R,
        M_RESP
    } mst_state_t;

endpackage

// ==== axi_read_master.sv ====
`timescale 1ns/1ps

module axi_read_master (
    input  logic             clk,
    input  logic             reset_i,
    // Shared request port
    input  rw_pkg::rw_req_t  req_i,
    output logic             ready_o,
    output rw_pkg::rw_resp_t resp_o,
    input  logic             data_ready_i,
    // AXI read channels
    output axi_pkg::axi_ar_t ar_o,
    input  logic             arready_i,
    input  axi_pkg::axi_r_t  r_i,
    output logic             rready_o
);
    import rw_pkg::*;
    import axi_pkg::*;

    mst_state_t        state_q;
    logic [addr_w-1:0] addr_q;
    rw_size_t          size_q;
    logic [data_w-1:0] data_q;
    logic [data_w-1:0] shifted;

    function automatic logic [2:0] size_to_arsize(input rw_size_t size);
        case (size)
            8'd1:    return 3'd0;
            8'd2:    return 3'd1;
            8'd4:    return 3'd2;
            default: return 3'd3;
        endcase
    endfunction

    // Keeps the low size bytes
    function automatic logic [data_w-1:0] size_mask(input rw_size_t size);
        case (size)
            8'd1:    return 64'h0000_0000_0000_00ff;
            8'd2:    return 64'h0000_0000_0000_ffff;
            8'd4:    return 64'h0000_0000_ffff_ffff;
            default: return 64'hffff_ffff_ffff_ffff;
        endcase
    endfunction

    // Addressed byte lane moved down to bit 0
    assign shifted = r_i.rdata >> {addr_q[2:0], 3'b000};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= M_IDLE;
        end else begin
            case (state_q)
                M_IDLE: if (req_i.valid) state_q <= M_AR;
                M_AR:   if (arready_i) state_q <= M_R;
                M_R:    if (r_i.rvalid) state_q <= M_RESP;
                M_RESP: if (data_ready_i) state_q <= M_IDLE;
                default: state_q <= M_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == M_IDLE && req_i.valid) begin
            addr_q <= req_i.addr;
            size_q <= req_i.size;
        end
        if (state_q == M_R && r_i.rvalid) begin
            // Error beat completes with zero data
            data_q <= (r_i.rresp == OKAY) ? (shifted & size_mask(size_q)) : '0;
        end
    end

    assign ready_o  = (state_q == M_IDLE);
    assign rready_o = (state_q == M_R);

    always_comb begin
        ar_o.arvalid = (state_q == M_AR);
        ar_o.araddr  = addr_q;
        ar_o.arlen   = 8'd0;  // Single beat
        ar_o.arsize  = size_to_arsize(size_q);
        ar_o.arburst = INCR;
    end

    always_comb begin
        resp_o.data_valid = (state_q == M_RESP);
        resp_o.data       = data_q;
    end

endmodule

// ==== axi_sram_slave.sv ====
`timescale 1ns/1ps

module axi_sram_slave (
    input  logic             clk,
    input  logic             reset_i,
    input  axi_pkg::axi_ar_t ar_i,
    output logic             arready_o,
    output axi_pkg::axi_r_t  r_o,
    input  logic             rready_i
);
    import rw_pkg::*;
    import axi_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_AR,
        S_R
    } slv_state_t;

    logic [data_w-1:0]     mem [sram_words];
    slv_state_t            state_q;
    logic [1:0]            delay_q;   // Remaining wait cycles
    logic [15:0]           lfsr_q;
    logic [data_w-1:0]     rdata_q;
    axi_resp_e             rresp_q;
    logic [addr_w-1:0]     offset;
    logic                  in_range;
    logic [sram_idx_w-1:0] word_idx;
    logic                  rvalid;

    // Word k holds k above and its inverse below
    initial begin
        for (int k = 0; k < sram_words; k++) begin
            mem[k] = {32'(k), ~32'(k)};
        end
    end

    assign offset   = ar_i.araddr - sram_base;
    assign in_range = (offset < addr_w'(sram_bytes));
    assign word_idx = offset[sram_idx_w+2:3];

    // Taps 16,14,13,11
    always_ff @(posedge clk) begin
        if (reset_i) begin
            lfsr_q <= 16'hace1;
        end else begin
            lfsr_q <= {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= S_IDLE;
            delay_q <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (ar_i.arvalid) begin
                        state_q <= S_AR;
                        delay_q <= lfsr_q[1:0];  // AR delay draw
                    end
                end
                S_AR: begin
                    if (delay_q == 2'd0) begin
                        state_q <= S_R;
                        delay_q <= lfsr_q[3:2];  // R delay draw
                    end else begin
                        delay_q <= delay_q - 2'd1;
                    end
                end
                S_R: begin
                    if (delay_q != 2'd0) begin
                        delay_q <= delay_q - 2'd1;
                    end else if (rready_i) begin
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // Array read on the address handshake
    always_ff @(posedge clk) begin
        if (arready_o) begin
            rdata_q <= in_range ? mem[word_idx] : '0;
            rresp_q <= in_range ? OKAY : SLVERR;
        end
    end

    assign arready_o = (state_q == S_AR) && (delay_q == 2'd0);
    assign rvalid    = (state_q == S_R) && (delay_q == 2'd0);

    always_comb begin
        r_o.rvalid = rvalid;
        r_o.rdata  = rdata_q;
        r_o.rresp  = rresp_q;
        r_o.rlast  = rvalid;  // Only beat of the burst
    end

endmodule

// ==== build.f ====
rw_pkg.sv
axi_pkg.sv
read_arbiter.sv
axi_read_master.sv
axi_sram_slave.sv
mem_read_subsys.sv
tb_clock_gen.sv
tb_properties.sv
tb_checker.sv
tb_top.sv

// ==== mem_read_subsys.sv ====
`timescale 1ns/1ps

module mem_read_subsys (
    input  logic             clk,
    input  logic             reset_i,
    // MEM requester
    input  rw_pkg::rw_req_t  mem_req_i,
    output logic             mem_ready_o,
    output rw_pkg::rw_resp_t mem_resp_o,
    input  logic             mem_data_ready_i,
    // IF requester
    input  rw_pkg::rw_req_t  if_req_i,
    output logic             if_ready_o,
    output rw_pkg::rw_resp_t if_resp_o,
    input  logic             if_data_ready_i
);
    import rw_pkg::*;
    import axi_pkg::*;

    // Shared port between arbiter and master
    rw_req_t  s_req;
    logic     s_ready;
    rw_resp_t s_resp;
    logic     s_data_ready;

    // AXI read channels
    axi_ar_t  ar;
    logic     arready;
    axi_r_t   r;
    logic     rready;

    read_arbiter i_read_arbiter (
        .clk              (clk),
        .reset_i          (reset_i),
        .mem_req_i        (mem_req_i),
        .mem_ready_o      (mem_ready_o),
        .mem_resp_o       (mem_resp_o),
        .mem_data_ready_i (mem_data_ready_i),
        .if_req_i         (if_req_i),
        .if_ready_o       (if_ready_o),
        .if_resp_o        (if_resp_o),
        .if_data_ready_i  (if_data_ready_i),
        .s_req_o          (s_req),
        .s_ready_i        (s_ready),
        .s_resp_i         (s_resp),
        .s_data_ready_o   (s_data_ready)
    );

    axi_read_master i_axi_read_master (
        .clk          (clk),
        .reset_i      (reset_i),
        .req_i        (s_req),
        .ready_o      (s_ready),
        .resp_o       (s_resp),
        .data_ready_i (s_data_ready),
        .ar_o         (ar),
        .arready_i    (arready),
        .r_i          (r),
        .rready_o     (rready)
    );

    axi_sram_slave i_axi_sram_slave (
        .clk       (clk),
        .reset_i   (reset_i),
        .ar_i      (ar),
        .arready_o (arready),
        .r_o       (r),
        .rready_i  (rready)
    );

endmodule

// ==== read_arbiter.sv ====
`timescale 1ns/1ps

module read_arbiter (
    input  logic             clk,
    input  logic             reset_i,
    // MEM requester
    input  rw_pkg::rw_req_t  mem_req_i,
    output logic             mem_ready_o,
    output rw_pkg::rw_resp_t mem_resp_o,
    input  logic             mem_data_ready_i,
    // IF requester
    input  rw_pkg::rw_req_t  if_req_i,
    output logic             if_ready_o,
    output rw_pkg::rw_resp_t if_resp_o,
    input  logic             if_data_ready_i,
    // Shared port toward the read master
    output rw_pkg::rw_req_t  s_req_o,
    input  logic             s_ready_i,
    input  rw_pkg::rw_resp_t s_resp_i,
    output logic             s_data_ready_o
);
    import rw_pkg::*;

    arb_state_t state_q;
    arb_state_t state_d;
    logic       mem_owns;
    logic       if_owns;

    assign mem_owns = (state_q == ARB_MEM);
    assign if_owns  = (state_q == ARB_IF);

    // MEM wins a tie, grant held until the owner's response completes
    always_comb begin
        state_d = state_q;
        case (state_q)
            ARB_IDLE: begin
                if (mem_req_i.valid) begin
                    state_d = ARB_MEM;
                end else if (if_req_i.valid) begin
                    state_d = ARB_IF;
                end
            end
            ARB_MEM: begin
                if (s_resp_i.data_valid && mem_data_ready_i) begin
                    state_d = ARB_IDLE;
                end
            end
            ARB_IF: begin
                if (s_resp_i.data_valid && if_data_ready_i) begin
                    state_d = ARB_IDLE;
                end
            end
            default: state_d = ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= ARB_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Owner's request goes out, nothing while idle
    assign s_req_o = mem_owns ? mem_req_i :
                     if_owns  ? if_req_i  : '0;
    assign s_data_ready_o = (mem_owns && mem_data_ready_i) ||
                            (if_owns && if_data_ready_i);

    // Non-owner sees zeros
    assign mem_ready_o = mem_owns && s_ready_i;
    assign if_ready_o  = if_owns && s_ready_i;
    assign mem_resp_o  = mem_owns ? s_resp_i : '0;
    assign if_resp_o   = if_owns ? s_resp_i : '0;

endmodule

// ==== run.sh ====
#!/bin/bash
# Build and run the read subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f build.f --top-module tb_top \
        --Mdir obj_dir -o sim_tb_top; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb_top +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "No errors" sim.log; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed"
exit 1

// ==== rw_pkg.sv ====
package rw_pkg;

    localparam int addr_w = 32;
    localparam int data_w = 64;

    // Byte count of one access, 1/2/4/8
    typedef logic [7:0] rw_size_t;

    // Request from a requester, or from the arbiter's shared port
    typedef struct packed {
        logic              valid;
        logic [addr_w-1:0] addr;
        rw_size_t          size;
    } rw_req_t;

    // Response with right-aligned, zero-extended data
    typedef struct packed {
        logic              data_valid;
        logic [data_w-1:0] data;
    } rw_resp_t;

    // Arbiter grant states
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_MEM,
        ARB_IF
    } arb_state_t;

endpackage

// ==== tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker (
    input  logic             clk,
    input  logic             reset_i,
    input  rw_pkg::rw_req_t  mem_req_i,
    input  logic             mem_ready_i,
    input  rw_pkg::rw_resp_t mem_resp_i,
    input  logic             mem_data_ready_i,
    input  rw_pkg::rw_req_t  if_req_i,
    input  logic             if_ready_i,
    input  rw_pkg::rw_resp_t if_resp_i,
    input  logic             if_data_ready_i,
    output int               error_count_o,
    output int               mem_count_o,
    output int               if_count_o
);
    import axi_pkg::*;

    localparam int sram_limit = sram_words * 8;  // Bytes in the SRAM

    logic [63:0] mem_exp_q [$];
    logic [63:0] if_exp_q [$];
    logic        reset_seen = 1'b0;
    logic        busy = 1'b0;        // Accepted request not yet answered
    logic [1:0]  grant_exp = 2'b00;  // {if, mem} ready due next cycle
    logic        idle;
    int          errors = 0;
    int          mem_count = 0;
    int          if_count = 0;

    assign error_count_o = errors;
    assign mem_count_o   = mem_count;
    assign if_count_o    = if_count;

    // Word k holds {k, ~k} and the addressed bytes are moved down
    function automatic logic [63:0] expected_data(input logic [31:0] addr,
                                                  input logic [7:0] size);
        logic [31:0] k;
        logic [63:0] lanes;
        if (addr >= sram_limit) begin
            return 64'd0;
        end
        k     = {23'd0, addr[11:3]};
        lanes = {k, ~k} >> (8 * addr[2:0]);
        return (size == 8'd8) ? lanes : lanes & ((64'd1 << (8 * size)) - 64'd1);
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s expected %h actual %h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        idle = !busy && !mem_ready_i && !if_ready_i;
        if (reset_seen) begin
            check_value("{mem_ready_o, if_ready_o, mem/if data_valid}", 64'd0,
                        64'({mem_ready_i, if_ready_i, mem_resp_i.data_valid,
                             if_resp_i.data_valid}));
        end
        if (!reset_i) begin
            if (grant_exp != 2'b00) begin
                check_value("{if_ready_o, mem_ready_o}", 64'(grant_exp),
                            64'({if_ready_i, mem_ready_i}));
            end
            if (mem_req_i.valid && mem_ready_i) begin
                mem_exp_q.push_back(expected_data(mem_req_i.addr, mem_req_i.size));
                busy = 1'b1;
            end
            if (if_req_i.valid && if_ready_i) begin
                if_exp_q.push_back(expected_data(if_req_i.addr, if_req_i.size));
                busy = 1'b1;
            end
            if (mem_resp_i.data_valid && mem_data_ready_i) begin
                if (mem_exp_q.size() == 0) begin
                    $display("Response on the MEM port at %0t with no request", $time);
                    errors++;
                end else begin
                    check_value("mem_resp_o.data", mem_exp_q.pop_front(), mem_resp_i.data);
                end
                mem_count++;
                busy = 1'b0;
            end
            if (if_resp_i.data_valid && if_data_ready_i) begin
                if (if_exp_q.size() == 0) begin
                    $display("Response on the IF port at %0t with no request", $time);
                    errors++;
                end else begin
                    check_value("if_resp_o.data", if_exp_q.pop_front(), if_resp_i.data);
                end
                if_count++;
                busy = 1'b0;
            end
            // MEM first when both wait on an idle arbiter
            grant_exp = !idle          ? 2'b00 :
                        mem_req_i.valid ? 2'b01 :
                        if_req_i.valid  ? 2'b10 : 2'b00;
        end
        reset_seen = reset_i;
    end

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset_o
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    // Held for the first 8 rising edges
    initial begin
        reset_o = 1'b1;
        repeat (8) @(posedge clk);
        reset_o <= 1'b0;
    end

endmodule

// ==== tb_properties.sv ====
`timescale 1ns/1ps

module tb_properties (
    input logic             clk,
    input logic             reset_i,
    input logic             mem_ready_i,
    input logic             if_ready_i,
    input rw_pkg::rw_resp_t mem_resp_i,
    input rw_pkg::rw_resp_t if_resp_i,
    input logic             mem_data_ready_i,
    input logic             if_data_ready_i
);
    int fail_count = 0;

    a_one_ready: assert property (@(posedge clk) disable iff (reset_i)
        !(mem_ready_i && if_ready_i))
        else begin
            $error("Both ready outputs high");
            fail_count++;
        end

    a_one_data_valid: assert property (@(posedge clk) disable iff (reset_i)
        !(mem_resp_i.data_valid && if_resp_i.data_valid))
        else begin
            $error("Both data_valid outputs high");
            fail_count++;
        end

    // Stalled response keeps its data
    a_mem_hold: assert property (@(posedge clk) disable iff (reset_i)
        mem_resp_i.data_valid && !mem_data_ready_i
        |=> mem_resp_i.data_valid && $stable(mem_resp_i.data))
        else begin
            $error("MEM response changed while stalled");
            fail_count++;
        end

    a_if_hold: assert property (@(posedge clk) disable iff (reset_i)
        if_resp_i.data_valid && !if_data_ready_i
        |=> if_resp_i.data_valid && $stable(if_resp_i.data))
        else begin
            $error("IF response changed while stalled");
            fail_count++;
        end

endmodule

bind mem_read_subsys tb_properties i_tb_properties (
    .clk              (clk),
    .reset_i          (reset_i),
    .mem_ready_i      (mem_ready_o),
    .if_ready_i       (if_ready_o),
    .mem_resp_i       (mem_resp_o),
    .if_resp_i        (if_resp_o),
    .mem_data_ready_i (mem_data_ready_i),
    .if_data_ready_i  (if_data_ready_i)
);

// ==== tb_top.sv ====
`timescale 1ns/1ps

module tb_top;
    import rw_pkg::*;

    localparam int n_req          = 150;
    localparam int timeout_cycles = 2 * n_req * 40;  // 12 cycles worst case plus gaps, stalls

    logic          clk;
    logic          reset;
    rw_req_t [1:0] req;         // Index 0 MEM, 1 IF
    logic    [1:0] data_ready;
    logic    [1:0] ready;
    logic    [1:0] data_valid;
    rw_resp_t      mem_resp;
    rw_resp_t      if_resp;
    int            issued [2];
    int            gap [2];
    int            phase [2];   // 0 gap, 1 request valid, 2 awaiting response
    int            cycles;
    int            other_errors;
    int            check_errors;
    int            assert_fails;
    int            mem_count;
    int            if_count;

    assign data_valid = {if_resp.data_valid, mem_resp.data_valid};

    tb_clock_gen i_tb_clock_gen (
        .clk     (clk),
        .reset_o (reset)
    );

    mem_read_subsys i_mem_read_subsys (
        .clk              (clk),
        .reset_i          (reset),
        .mem_req_i        (req[0]),
        .mem_ready_o      (ready[0]),
        .mem_resp_o       (mem_resp),
        .mem_data_ready_i (data_ready[0]),
        .if_req_i         (req[1]),
        .if_ready_o       (ready[1]),
        .if_resp_o        (if_resp),
        .if_data_ready_i  (data_ready[1])
    );

    tb_checker i_tb_checker (
        .clk              (clk),
        .reset_i          (reset),
        .mem_req_i        (req[0]),
        .mem_ready_i      (ready[0]),
        .mem_resp_i       (mem_resp),
        .mem_data_ready_i (data_ready[0]),
        .if_req_i         (req[1]),
        .if_ready_i       (ready[1]),
        .if_resp_i        (if_resp),
        .if_data_ready_i  (data_ready[1]),
        .error_count_o    (check_errors),
        .mem_count_o      (mem_count),
        .if_count_o       (if_count)
    );

    // Naturally aligned, about 5% beyond the SRAM
    function automatic rw_req_t random_request();
        rw_req_t     r;
        logic [31:0] size;
        size    = 32'd1 << $urandom_range(3, 0);
        r.valid = 1'b1;
        r.size  = size[7:0];
        r.addr  = ($urandom_range(99, 0) < 5) ? ($urandom | 32'h0000_1000)
                                              : $urandom_range(4095, 0);
        r.addr  = r.addr & ~(size - 32'd1);
        return r;
    endfunction

    function automatic logic all_done();
        return issued[0] == n_req && issued[1] == n_req && phase[0] == 0 && phase[1] == 0;
    endfunction

    initial begin
        logic idx;
        void'($urandom(32'hc5e7));
        req          = '0;
        data_ready   = '0;
        cycles       = 0;
        other_errors = 0;
        issued       = '{0, 0};
        gap          = '{0, 0};
        phase        = '{0, 0};
        wait (reset === 1'b0);
        while (!all_done() && cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
            for (int r = 0; r < 2; r++) begin
                idx = 1'(r);
                case (phase[idx])
                    0: begin
                        if (gap[idx] > 0) begin
                            gap[idx]--;
                        end else if (issued[idx] < n_req) begin
                            req[idx] <= random_request();
                            issued[idx]++;
                            phase[idx] = 1;
                        end
                    end
                    1: begin
                        if (ready[idx]) begin
                            req[idx].valid <= 1'b0;  // Accepted on this edge
                            phase[idx] = 2;
                        end
                    end
                    default: begin
                        if (data_valid[idx] && data_ready[idx]) begin
                            gap[idx]   = $urandom_range(3, 0);
                            phase[idx] = 0;
                        end
                    end
                endcase
            end
            data_ready <= {$urandom_range(99, 0) < 70, $urandom_range(99, 0) < 70};
        end
        if (!all_done()) begin
            $display("Timeout after %0d cycles with requests still outstanding", cycles);
            other_errors++;
        end
        repeat (2) @(posedge clk);
        if (mem_count != n_req || if_count != n_req) begin
            $display("Response counts differ from the %0d requests issued per port", n_req);
            other_errors++;
        end
        assert_fails = i_mem_read_subsys.i_tb_properties.fail_count;
        $display("Summary: %0d MEM and %0d IF responses, %0d check, %0d assertion, %0d other",
                 mem_count, if_count, check_errors, assert_fails, other_errors);
        if (check_errors + assert_fails + other_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
